//--- Makefile
VERILATOR  ?= verilator
TOP        := tbTop
FILELIST   := tb.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing -Wno-fatal -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
PASS_MSG   := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# exit status comes from grep, so a missing pass line fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- hw/execUnit.sv
`timescale 1ns/100ps

module execUnit (
  input  logic                      clk,
  input  logic                      rst,
  issueIf.exe                       dec,    // decode group in
  issueIf.exe                       res,    // result group out
  input  logic [rfPkg::LaneN-1:0]   wr,     // write port from write-back
  input  logic [rfPkg::RfAddrW-1:0] wa,
  input  logic [rfPkg::ValueW-1:0]  wd
);

  logic [rfPkg::ValueW-1:0] opA;            // rs operand, copy A
  logic [rfPkg::ValueW-1:0] opB;            // rt operand, copy B
  logic [rfPkg::ValueW-1:0] aluOut;

  // decode fields delayed one cycle to line up with the operands
  logic                     s1Valid;
  logic [rfPkg::OpW-1:0]    s1Op;
  logic                     s1IsImm;
  logic                     s1IsRead;
  logic [rfPkg::TidW-1:0]   s1Tid;
  logic [rfPkg::RegW-1:0]   s1Rd;
  logic [rfPkg::LaneN-1:0]  s1Mask;
  logic [rfPkg::ValueW-1:0] s1Imm;

  // ======================================
  // register file copies
  // ======================================
  // both copies take every write, so they always hold the same data
  gprRegfile gprA_i (
    .clk (clk),
    .wr  (wr),
    .wa  (wa),
    .wd  (wd),
    .ra  ({dec.dTid, dec.dRs}),
    .rd  (opA)
  );

  gprRegfile gprB_i (
    .clk (clk),
    .wr  (wr),
    .wa  (wa),
    .wd  (wd),
    .ra  ({dec.dTid, dec.dRt}),
    .rd  (opB)
  );

  // ======================================
  // operand stage, edge E1
  // ======================================
  always_ff @(posedge clk) begin
    if (rst) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= dec.dValid;
    end
    s1Op     <= dec.dOp;
    s1IsImm  <= dec.dIsImm;
    s1IsRead <= dec.dIsRead;
    s1Tid    <= dec.dTid;
    s1Rd     <= dec.dRd;
    s1Mask   <= dec.dLaneMask;
    s1Imm    <= dec.dImm;
  end

  // alu, or the lane immediate for byte and half loads
  always_comb begin
    if (s1IsImm) begin
      aluOut = s1Imm;                       // lanes picked later by the mask
    end else begin
      case (s1Op)
        rfPkg::OpAdd: aluOut = opA + opB;
        rfPkg::OpSub: aluOut = opA - opB;   // wraps modulo 2^32
        rfPkg::OpAnd: aluOut = opA & opB;
        rfPkg::OpOr:  aluOut = opA | opB;
        rfPkg::OpXor: aluOut = opA ^ opB;
        default:      aluOut = opA;         // read passes rs through
      endcase
    end
  end

  // ======================================
  // result stage, edge E2
  // ======================================
  always_ff @(posedge clk) begin
    if (rst) begin
      res.xValid <= 1'b0;
    end else begin
      res.xValid <= s1Valid;
    end
    res.xIsRead <= s1IsRead;
    res.xTid    <= s1Tid;
    res.xRd     <= s1Rd;
    res.xMask   <= s1IsRead ? '0 : s1Mask;  // reads never touch the file
    res.xValue  <= aluOut;
  end

endmodule

//--- hw/gprRegfile.sv
`timescale 1ns/100ps

module gprRegfile (
  input  logic                      clk,
  input  logic [rfPkg::LaneN-1:0]   wr,     // byte lane write enables
  input  logic [rfPkg::RfAddrW-1:0] wa,     // {tid, reg}
  input  logic [rfPkg::ValueW-1:0]  wd,
  input  logic [rfPkg::RfAddrW-1:0] ra,     // {tid, reg}
  output logic [rfPkg::ValueW-1:0]  rd
);

  // all threads share one array, thread number in the upper address bits
  (* ram_style = "block" *)
  logic [rfPkg::ValueW-1:0]  mem [rfPkg::NThreads*rfPkg::NRegs];
  logic [rfPkg::RfAddrW-1:0] raR;           // registered read address

  // contents start at zero, like a freshly configured block ram
  initial begin
    for (int k = 0; k < rfPkg::NThreads * rfPkg::NRegs; k++) begin
      mem[k] = '0;
    end
  end

  // ======================================
  // write port
  // ======================================
  always_ff @(posedge clk) begin
    for (int i = 0; i < rfPkg::LaneN; i++) begin
      if (wr[i]) begin
        mem[wa][i*rfPkg::ByteW +: rfPkg::ByteW] <= wd[i*rfPkg::ByteW +: rfPkg::ByteW];
      end
    end
  end

  // ======================================
  // read port
  // ======================================
  always_ff @(posedge clk) begin
    raR <= ra;                              // edge E1
  end

  // r0 of every thread reads zero whatever was stored there
  assign rd = (raR[rfPkg::RegW-1:0] == '0) ? '0 : mem[raR];

endmodule

//--- hw/instDecode.sv
`timescale 1ns/100ps

module instDecode (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    instValid,
  input  logic [rfPkg::InstW-1:0] inst,
  input  logic [rfPkg::TidW-1:0]  instTid,
  issueIf.dec                     dec
);

  rfPkg::instrU             word;       // one word, rForm and iForm views
  logic                     opOk;       // known, non-nop opcode
  logic                     isImm;
  logic                     isRead;
  logic [rfPkg::RegW-1:0]   dstReg;
  logic [rfPkg::LaneN-1:0]  laneMask;
  logic [rfPkg::ValueW-1:0] immRep;

  assign word = inst;

  // ======================================
  // opcode decode
  // ======================================
  always_comb begin
    isImm    = 1'b0;
    isRead   = 1'b0;
    dstReg   = word.rForm.rd;
    laneMask = '1;                                  // alu ops write all lanes
    immRep   = '0;
    case (word.rForm.op)
      rfPkg::OpAdd, rfPkg::OpSub, rfPkg::OpAnd, rfPkg::OpOr, rfPkg::OpXor: begin
        opOk = 1'b1;                                // rd = rs op rt
      end
      rfPkg::OpLdb: begin
        opOk     = 1'b1;
        isImm    = 1'b1;
        laneMask = '0;
        laneMask[word.iForm.lane] = 1'b1;           // one-hot byte lane
        immRep   = {rfPkg::LaneN{word.iForm.imm16[rfPkg::ByteW-1:0]}};
      end
      rfPkg::OpLdh: begin
        opOk     = 1'b1;
        isImm    = 1'b1;
        // lane bit 0 picks the upper or lower half
        laneMask = {{(rfPkg::LaneN/2){word.iForm.lane[0]}},
                    {(rfPkg::LaneN/2){~word.iForm.lane[0]}}};
        immRep   = {2{word.iForm.imm16}};
      end
      rfPkg::OpRd: begin
        opOk   = 1'b1;
        isRead = 1'b1;
        dstReg = word.rForm.rs;                     // reported register is rs
      end
      rfPkg::OpNop: begin
        opOk = 1'b0;                                // empty slot
      end
      default: begin
        opOk = 1'b0;                                // unknown code, same as nop
      end
    endcase
  end

  // ======================================
  // decode register, edge E0
  // ======================================
  always_ff @(posedge clk) begin
    if (rst) begin
      dec.dValid <= 1'b0;
    end else begin
      dec.dValid <= instValid & opOk;               // dropped ops never issue
    end
    dec.dOp       <= word.rForm.op;
    dec.dIsImm    <= isImm;
    dec.dIsRead   <= isRead;
    dec.dTid      <= instTid;
    dec.dRd       <= dstReg;
    dec.dRs       <= word.rForm.rs;                 // don't care for imm ops
    dec.dRt       <= word.rForm.rt;
    dec.dLaneMask <= laneMask;
    dec.dImm      <= immRep;
  end

endmodule

//--- hw/issueIf.sv
`timescale 1ns/100ps

interface issueIf;

  // ======================================
  // decode group, decode to execute
  // ======================================
  logic                       dValid;     // slot holds a real instruction
  logic [rfPkg::OpW-1:0]      dOp;        // alu select
  logic                       dIsImm;     // result comes from dImm
  logic                       dIsRead;    // send value out, no write
  logic [rfPkg::TidW-1:0]     dTid;
  logic [rfPkg::RegW-1:0]     dRd;        // destination, or the reg being read
  logic [rfPkg::RegW-1:0]     dRs;
  logic [rfPkg::RegW-1:0]     dRt;
  logic [rfPkg::LaneN-1:0]    dLaneMask;  // byte lanes to write
  logic [rfPkg::ValueW-1:0]   dImm;       // byte or half replicated

  // ======================================
  // result group, execute to write-back
  // ======================================
  logic                       xValid;
  logic                       xIsRead;
  logic [rfPkg::TidW-1:0]     xTid;
  logic [rfPkg::RegW-1:0]     xRd;
  logic [rfPkg::LaneN-1:0]    xMask;      // zero for reads
  logic [rfPkg::ValueW-1:0]   xValue;

  modport dec (
    output dValid, dOp, dIsImm, dIsRead, dTid, dRd, dRs, dRt, dLaneMask, dImm
  );

  modport exe (
    input  dValid, dOp, dIsImm, dIsRead, dTid, dRd, dRs, dRt, dLaneMask, dImm,
    output xValid, xIsRead, xTid, xRd, xMask, xValue
  );

  modport wb (
    input xValid, xIsRead, xTid, xRd, xMask, xValue
  );

endinterface

//--- hw/rfPkg.sv
package rfPkg;

  // ======================================
  // sizes
  // ======================================
  localparam int NThreads = 4;                    // barrel threads
  localparam int NRegs    = 64;                   // registers per thread
  localparam int TidW     = $clog2(NThreads);     // thread number width
  localparam int RegW     = $clog2(NRegs);        // register number width
  localparam int RfAddrW  = TidW + RegW;          // {tid, reg}
  localparam int ValueW   = 32;                   // register width
  localparam int ByteW    = 8;
  localparam int LaneN    = ValueW / ByteW;       // byte lanes per register
  localparam int LaneSelW = $clog2(LaneN);        // lane field in iForm
  localparam int InstW    = 32;                   // instruction word
  localparam int OpW      = 4;                    // opcode width
  localparam int ImmW     = 16;                   // immediate field

  // ======================================
  // opcodes
  // ======================================
  // any code not listed here is treated as a nop
  localparam logic [OpW-1:0] OpNop = 4'd0;
  localparam logic [OpW-1:0] OpAdd = 4'd1;        // rd = rs + rt
  localparam logic [OpW-1:0] OpSub = 4'd2;        // rd = rs - rt
  localparam logic [OpW-1:0] OpAnd = 4'd3;
  localparam logic [OpW-1:0] OpOr  = 4'd4;
  localparam logic [OpW-1:0] OpXor = 4'd5;
  localparam logic [OpW-1:0] OpLdb = 4'd6;        // one byte lane of rd from imm[7:0]
  localparam logic [OpW-1:0] OpLdh = 4'd7;        // one half of rd from imm16
  localparam logic [OpW-1:0] OpRd  = 4'd8;        // rs to the result port

  // ======================================
  // instruction word
  // ======================================
  // register form and immediate form share op and rd
  typedef union packed {
    struct packed {
      logic [OpW-1:0]  op;      // 31..28
      logic [RegW-1:0] rd;      // 27..22
      logic [RegW-1:0] rs;      // 21..16
      logic [RegW-1:0] rt;      // 15..10
      logic [9:0]      unused;
    } rForm;
    struct packed {
      logic [OpW-1:0]      op;      // 31..28
      logic [RegW-1:0]     rd;      // 27..22
      logic [LaneSelW-1:0] lane;    // 21..20
      logic [3:0]          unused;  // 19..16
      logic [ImmW-1:0]     imm16;   // 15..0
    } iForm;
  } instrU;

endpackage

//--- hw/rfSlice.sv
`timescale 1ns/100ps

module rfSlice (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     instValid,
  input  logic [rfPkg::InstW-1:0]  inst,
  input  logic [rfPkg::TidW-1:0]   instTid,
  output logic                     resValid,
  output logic [rfPkg::TidW-1:0]   resTid,
  output logic [rfPkg::RegW-1:0]   resReg,
  output logic [rfPkg::ValueW-1:0] res
);

  issueIf issue ();                           // decode and result groups

  // write-back to register file port
  logic [rfPkg::LaneN-1:0]   wr;
  logic [rfPkg::RfAddrW-1:0] wa;
  logic [rfPkg::ValueW-1:0]  wd;

  instDecode instDecode_i (
    .clk       (clk),
    .rst       (rst),
    .instValid (instValid),
    .inst      (inst),
    .instTid   (instTid),
    .dec       (issue.dec)
  );

  execUnit execUnit_i (
    .clk (clk),
    .rst (rst),
    .dec (issue.exe),
    .res (issue.exe),
    .wr  (wr),
    .wa  (wa),
    .wd  (wd)
  );

  writeBack writeBack_i (
    .clk      (clk),
    .rst      (rst),
    .resIf    (issue.wb),
    .wr       (wr),
    .wa       (wa),
    .wd       (wd),
    .resValid (resValid),
    .resTid   (resTid),
    .resReg   (resReg),
    .res      (res)
  );

endmodule

//--- hw/writeBack.sv
`timescale 1ns/100ps

module writeBack (
  input  logic                      clk,
  input  logic                      rst,
  issueIf.wb                        resIf,      // result group from execute
  output logic [rfPkg::LaneN-1:0]   wr,         // write port to both copies
  output logic [rfPkg::RfAddrW-1:0] wa,
  output logic [rfPkg::ValueW-1:0]  wd,
  output logic                      resValid,   // one cycle per read
  output logic [rfPkg::TidW-1:0]    resTid,
  output logic [rfPkg::RegW-1:0]    resReg,
  output logic [rfPkg::ValueW-1:0]  res
);

  logic                     validR;
  logic                     isReadR;
  logic [rfPkg::TidW-1:0]   tidR;
  logic [rfPkg::RegW-1:0]   rdR;
  logic [rfPkg::LaneN-1:0]  maskR;
  logic [rfPkg::ValueW-1:0] valueR;

  // ======================================
  // result register, edge E3
  // ======================================
  always_ff @(posedge clk) begin
    if (rst) begin
      validR <= 1'b0;
    end else begin
      validR <= resIf.xValid;
    end
    isReadR <= resIf.xIsRead;
    tidR    <= resIf.xTid;
    rdR     <= resIf.xRd;
    maskR   <= resIf.xMask;
    valueR  <= resIf.xValue;
  end

  // write port, the files take it at edge E4
  assign wr = (validR & ~isReadR) ? maskR : '0;
  assign wa = {tidR, rdR};
  assign wd = valueR;

  // external result port, shares the same register
  assign resValid = validR & isReadR;
  assign resTid   = tidR;
  assign resReg   = rdR;                        // the rs that was read
  assign res      = valueR;

endmodule

//--- tb.f
hw/rfPkg.sv
hw/issueIf.sv
hw/instDecode.sv
hw/gprRegfile.sv
hw/execUnit.sv
hw/writeBack.sv
hw/rfSlice.sv
verif/rfChecker.sv
verif/tbTop.sv

//--- verif/rfChecker.sv
`timescale 1ns/100ps

module rfChecker (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     instValid,
  input  logic [rfPkg::InstW-1:0]  inst,
  input  logic [rfPkg::TidW-1:0]   instTid,
  input  logic                     resValid,
  input  logic [rfPkg::TidW-1:0]   resTid,
  input  logic [rfPkg::RegW-1:0]   resReg,
  input  logic [rfPkg::ValueW-1:0] res,
  input  int                       testNum,
  input  logic                     endTest,
  input  logic                     runDone,
  output int                       errCount
);

  localparam int EntryW = rfPkg::TidW + rfPkg::RegW + rfPkg::ValueW;

  logic [rfPkg::ValueW-1:0] model [rfPkg::NThreads][rfPkg::NRegs];
  logic [EntryW-1:0]        pending [$];            // {tid, reg, value} per read
  int testRds  = 0;                                 // reads issued this test
  int testRes  = 0;                                 // resValid pulses this test
  int testErrs = 0;
  int totalRds = 0;
  int testsRun = 0;

  initial begin
    errCount = 0;
    foreach (model[t, r]) model[t][r] = '0;         // register files start at zero
  end

  // ======================================
  // reference model
  // ======================================
  function automatic logic [31:0] readModel(input logic [1:0] tid, input logic [5:0] r);
    return (r == 6'd0) ? 32'd0 : model[tid][r];     // r0 reads zero
  endfunction

  // new value of rd for one instruction
  function automatic logic [31:0] predictOp(input rfPkg::instrU w, input logic [31:0] a,
                                            input logic [31:0] b, input logic [31:0] old);
    logic [31:0] v;
    v = old;
    case (w.rForm.op)
      rfPkg::OpAdd: v = a + b;
      rfPkg::OpSub: v = a - b;
      rfPkg::OpAnd: v = a & b;
      rfPkg::OpOr:  v = a | b;
      rfPkg::OpXor: v = a ^ b;
      rfPkg::OpLdb: v[w.iForm.lane*8 +: 8] = w.iForm.imm16[7:0];
      rfPkg::OpLdh: begin
        if (w.iForm.lane[0]) v[31:16] = w.iForm.imm16;
        else v[15:0] = w.iForm.imm16;
      end
      default: v = old;                             // nop, read, unknown
    endcase
    return v;
  endfunction

  task automatic applyInst(input rfPkg::instrU w, input logic [1:0] tid);
    logic [31:0] a;
    logic [31:0] b;
    a = readModel(tid, w.rForm.rs);
    b = readModel(tid, w.rForm.rt);
    if (w.rForm.op == rfPkg::OpRd) begin
      pending.push_back({tid, w.rForm.rs, a});
      testRds++;
    end
    model[tid][w.rForm.rd] = predictOp(w, a, b, model[tid][w.rForm.rd]);
  endtask

  // ======================================
  // compare
  // ======================================
  task automatic compareResult();
    logic [EntryW-1:0] e;
    testRes++;
    if (pending.size() == 0) begin
      $display("result at %0t for thread %0d reg %0d came with no read outstanding",
               $time, resTid, resReg);
      testErrs++;
    end else begin
      e = pending.pop_front();
      if (e != {resTid, resReg, res}) begin
        $display("** Error at %0t: thread %0d reg %0d expected %h, seen thread %0d reg %0d %h",
                 $time, e[39:38], e[37:32], e[31:0], resTid, resReg, res);
        testErrs++;
      end
    end
  endtask

  task automatic closeTest();
    if (pending.size() != 0) begin
      $display("test %0d ended with %0d reads still waiting", testNum, pending.size());
      testErrs++;
      pending.delete();
    end
    if (testRes != testRds) begin
      $display("test %0d: %0d reads issued but %0d results seen", testNum, testRds, testRes);
      testErrs++;
    end
    $display("test %0d: %0d reads, %0d results, %0d errors", testNum, testRds, testRes, testErrs);
    errCount += testErrs;
    totalRds += testRds;
    testsRun++;
    testRds  = 0;
    testRes  = 0;
    testErrs = 0;
  endtask

  // sampled on the edge, inputs and outputs are settled by then
  always @(posedge clk) begin
    if (!rst) begin
      if (resValid) compareResult();
      if (instValid) applyInst(inst, instTid);
      if (endTest) closeTest();
      if (runDone) begin
        $display("summary: %0d tests, %0d reads checked, %0d errors", testsRun, totalRds,
                 errCount);
      end
    end
  end

endmodule

//--- verif/tbTop.sv
`timescale 1ns/100ps

module tbTop;

  localparam int ClkPeriod = 8;                     // ns
  localparam int RstCycles = 16;
  // instructions issued by each test
  localparam int InstT1 = 32;
  localparam int InstT2 = 48;
  localparam int InstT3 = 280;
  localparam int InstT4 = 12;
  localparam int InstT5 = 20;
  localparam int InstT6 = 400;
  localparam int NInst  = InstT1 + InstT2 + InstT3 + InstT4 + InstT5 + InstT6;
  localparam int WatchdogCycles = 20 * NInst + 200;

  logic                       clk;
  logic                       rst;
  logic                       instValid;
  logic [rfPkg::InstW-1:0]    inst;
  logic [rfPkg::TidW-1:0]     instTid;
  logic                       resValid;
  logic [rfPkg::TidW-1:0]     resTid;
  logic [rfPkg::RegW-1:0]     resReg;
  logic [rfPkg::ValueW-1:0]   res;
  int                         testNum;            // to the checker
  logic                       endTest;            // one-cycle pulse per test
  logic                       runDone;
  int                         errCount;
  integer                     seed;
  logic [31:0]                rnd;
  logic [rfPkg::TidW-1:0]     rrTid;              // next thread in the barrel
  logic [rfPkg::RegW-1:0]     rdSel [rfPkg::NThreads];

  rfSlice rfSlice_i (
    .clk       (clk),
    .rst       (rst),
    .instValid (instValid),
    .inst      (inst),
    .instTid   (instTid),
    .resValid  (resValid),
    .resTid    (resTid),
    .resReg    (resReg),
    .res       (res)
  );

  rfChecker rfChecker_i (
    .clk       (clk),
    .rst       (rst),
    .instValid (instValid),
    .inst      (inst),
    .instTid   (instTid),
    .resValid  (resValid),
    .resTid    (resTid),
    .resReg    (resReg),
    .res       (res),
    .testNum   (testNum),
    .endTest   (endTest),
    .runDone   (runDone),
    .errCount  (errCount)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // watchdog, bound scales with the number of instructions
  initial begin
    #(ClkPeriod * WatchdogCycles);
    $display("watchdog expired after %0d cycles, the run never finished", WatchdogCycles);
    $display("Verification failed");
    $finish;
  end

  // ======================================
  // stimulus helpers
  // ======================================
  function automatic logic [31:0] aluWord(input logic [3:0] op, input logic [5:0] rd,
                                          input logic [5:0] rs, input logic [5:0] rt);
    rfPkg::instrU w;
    w          = '0;
    w.rForm.op = op;
    w.rForm.rd = rd;
    w.rForm.rs = rs;
    w.rForm.rt = rt;
    return w;
  endfunction

  function automatic logic [31:0] immWord(input logic [3:0] op, input logic [5:0] rd,
                                          input logic [1:0] lane, input logic [15:0] imm);
    rfPkg::instrU w;
    w             = '0;
    w.iForm.op    = op;
    w.iForm.rd    = rd;
    w.iForm.lane  = lane;
    w.iForm.imm16 = imm;
    return w;
  endfunction

  // one instruction on the next edge, threads taken round-robin
  task automatic issueInst(input logic [31:0] w);
    @(posedge clk);
    instValid <= 1'b1;
    inst      <= w;
    instTid   <= rrTid;
    rrTid     = rrTid + 1'b1;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      instValid <= 1'b0;
    end
  endtask

  // pipeline is 4 deep, 10 idle cycles drain it
  task automatic finishTest(input int num);
    idleCycles(10);
    @(posedge clk);
    testNum <= num;
    endTest <= 1'b1;
    @(posedge clk);
    endTest <= 1'b0;
  endtask

  // ======================================
  // tests
  // ======================================
  initial begin
    seed      = 32'h33fa;
    rst       = 1'b1;
    instValid = 1'b0;
    inst      = '0;
    instTid   = '0;
    testNum   = 0;
    endTest   = 1'b0;
    runDone   = 1'b0;
    rrTid     = '0;
    repeat (RstCycles) @(posedge clk);
    rst <= 1'b0;

    // 1: quiet after reset, then random reads see zero
    idleCycles(12);
    repeat (InstT1) begin
      rnd = $random(seed);
      issueInst(aluWord(rfPkg::OpRd, 6'd0, rnd[5:0], 6'd0));
    end
    finishTest(1);

    // 2: byte lanes then halves of r20
    for (int l = 0; l < rfPkg::LaneN; l++) begin
      repeat (rfPkg::NThreads) begin
        rnd = $random(seed);
        issueInst(immWord(rfPkg::OpLdb, 6'd20, 2'(l), rnd[15:0]));
      end
      repeat (rfPkg::NThreads) issueInst(aluWord(rfPkg::OpRd, 6'd0, 6'd20, 6'd0));
    end
    for (int h = 0; h < 2; h++) begin
      repeat (rfPkg::NThreads) begin
        rnd = $random(seed);
        issueInst(immWord(rfPkg::OpLdh, 6'd20, {rnd[16], 1'(h)}, rnd[15:0]));  // lane bit 1 ignored
      end
      repeat (rfPkg::NThreads) issueInst(aluWord(rfPkg::OpRd, 6'd0, 6'd20, 6'd0));
    end
    finishTest(2);

    // 3: random operands in r1..r15, then alu rounds
    for (int r = 1; r < 16; r++) begin
      for (int h = 0; h < 2; h++) begin
        repeat (rfPkg::NThreads) begin
          rnd = $random(seed);
          issueInst(immWord(rfPkg::OpLdh, 6'(r), 2'(h), rnd[15:0]));
        end
      end
    end
    for (int n = 0; n < 20; n++) begin
      for (int k = 0; k < rfPkg::NThreads; k++) begin
        rnd      = $random(seed);
        rdSel[k] = 6'd16 + {1'b0, rnd[4:0]};           // results land in r16..r47
        issueInst(aluWord(4'(rfPkg::OpAdd + n % 5), rdSel[k],
                          6'd1 + {1'b0, rnd[12:8]}, 6'd16 + {1'b0, rnd[20:16]}));
      end
      for (int k = 0; k < rfPkg::NThreads; k++) begin
        issueInst(aluWord(rfPkg::OpRd, 6'd0, rdSel[k], 6'd0));
      end
    end
    finishTest(3);

    // 4: r33 differs per thread
    for (int k = 0; k < rfPkg::NThreads; k++) begin
      issueInst(immWord(rfPkg::OpLdh, 6'd33, 2'd0, 16'(16'h1111 * (k + 1))));
    end
    repeat (rfPkg::NThreads) begin
      rnd = $random(seed);
      issueInst(immWord(rfPkg::OpLdh, 6'd33, 2'd1, rnd[15:0]));
    end
    repeat (rfPkg::NThreads) issueInst(aluWord(rfPkg::OpRd, 6'd0, 6'd33, 6'd0));
    finishTest(4);

    // 5: writes to r0 are lost, r0 as a source is zero
    repeat (rfPkg::NThreads) issueInst(immWord(rfPkg::OpLdh, 6'd0, 2'd0, 16'hbeef));
    repeat (rfPkg::NThreads) issueInst(immWord(rfPkg::OpLdb, 6'd0, 2'd3, 16'h00ff));
    repeat (rfPkg::NThreads) issueInst(aluWord(rfPkg::OpRd, 6'd0, 6'd0, 6'd0));
    repeat (rfPkg::NThreads) issueInst(aluWord(rfPkg::OpAdd, 6'd40, 6'd0, 6'd7));
    repeat (rfPkg::NThreads) issueInst(aluWord(rfPkg::OpRd, 6'd0, 6'd40, 6'd0));
    finishTest(5);

    // 6: back-to-back random words, codes 9..15 are unknown
    repeat (InstT6) begin
      rnd = $random(seed);
      issueInst(rnd);
    end
    finishTest(6);

    @(posedge clk);
    runDone <= 1'b1;
    @(posedge clk);
    runDone <= 1'b0;
    @(posedge clk);                                  // summary line goes first
    if (errCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
